// File: src/cpu_pkg.sv
package cpu_pkg;

    // Bus and register widths
    typedef logic [7:0]  data_t;            // One bus byte or register value
    typedef logic [15:0] addr_t;            // Memory address

    // Status flags. The same type carries values and per-bit write masks
    typedef logic [2:0]  flags_t;

    localparam int FLAG_C = 0;              // Carry
    localparam int FLAG_Z = 1;              // Zero
    localparam int FLAG_N = 2;              // Negative

    localparam flags_t FLAGS_NONE = 3'b000; // No flag update
    localparam flags_t FLAGS_ZN   = 3'b110; // Loads touch Z and N only
    localparam flags_t FLAGS_CZN  = 3'b111; // Arithmetic and shifts

    // ALU operation select
    typedef logic [1:0] alu_op_t;

    localparam alu_op_t ALU_PASS_M = 2'd0;  // Input data latch unchanged
    localparam alu_op_t ALU_ADC    = 2'd1;  // A + M + C
    localparam alu_op_t ALU_ASL_A  = 2'd2;  // Shift accumulator left
    localparam alu_op_t ALU_ASL_M  = 2'd3;  // Shift latch left

    // Supported opcodes, standard 6502 encodings
    localparam data_t OP_LDA_IMM = 8'hA9;
    localparam data_t OP_LDA_ZPG = 8'hA5;
    localparam data_t OP_STA_ZPG = 8'h85;
    localparam data_t OP_ASL_A   = 8'h0A;
    localparam data_t OP_ASL_ZPG = 8'h06;
    localparam data_t OP_ADC_IMM = 8'h69;
    localparam data_t OP_BEQ     = 8'hF0;
    localparam data_t OP_BMI     = 8'h30;
    localparam data_t OP_NOP     = 8'hEA;

    // Decoder states
    typedef enum logic [2:0] {
        S_FETCH,                            // Opcode read, sync high
        S_OPERAND,                          // Operand byte read
        S_ZPG_READ,                         // Zero-page byte read
        S_MODIFY,                           // ALU pass of a read-modify-write
        S_WRITE,                            // Bus write from the data buffer
        S_BRANCH                            // PC plus relative offset
    } decode_state_t;

endpackage

// File: src/alu.sv
`timescale 1ns/1ps

module alu (
    input  cpu_pkg::alu_op_t alu_op,
    input  cpu_pkg::data_t   acc,
    input  cpu_pkg::data_t   idl,
    input  logic             carry_in,
    output cpu_pkg::data_t   result,
    output cpu_pkg::flags_t  flags_out
);

    logic [8:0] sum;                        // Ninth bit is the carry out
    logic       carry;

    assign sum = {1'b0, acc} + {1'b0, idl} + {8'd0, carry_in};

    always_comb begin
        result = idl;
        carry  = carry_in;

        case (alu_op)
            cpu_pkg::ALU_PASS_M: begin
                result = idl;
                carry  = carry_in;          // Loads keep the carry
            end
            cpu_pkg::ALU_ADC: begin
                result = sum[7:0];
                carry  = sum[8];
            end
            cpu_pkg::ALU_ASL_A: begin
                result = {acc[6:0], 1'b0};
                carry  = acc[7];            // Bit shifted out
            end
            cpu_pkg::ALU_ASL_M: begin
                result = {idl[6:0], 1'b0};
                carry  = idl[7];
            end
            default: begin
                result = idl;
                carry  = carry_in;
            end
        endcase
    end

    // Z and N follow the result for every operation
    always_comb begin
        flags_out                 = '0;
        flags_out[cpu_pkg::FLAG_C] = carry;
        flags_out[cpu_pkg::FLAG_Z] = (result == 8'h00);
        flags_out[cpu_pkg::FLAG_N] = result[7];
    end

endmodule

// File: src/datapath.sv
`timescale 1ns/1ps

module datapath #(
    parameter cpu_pkg::addr_t RESET_PC = 16'h0200
) (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            rdy,
    input  cpu_pkg::data_t  mem_rdata,
    input  logic            pc_inc,
    input  logic            pc_branch,
    input  logic            addr_sel,
    input  logic            idl_load,
    input  logic            zp_load,
    input  logic            acc_load,
    input  logic            acc_from_alu,
    input  logic            dbuf_load,
    input  cpu_pkg::flags_t flags_load,
    input  cpu_pkg::data_t  alu_result,
    input  cpu_pkg::flags_t alu_flags,
    output cpu_pkg::data_t  acc,
    output cpu_pkg::data_t  idl,
    output cpu_pkg::flags_t flags,
    output cpu_pkg::addr_t  mem_addr,
    output cpu_pkg::data_t  mem_wdata
);

    cpu_pkg::addr_t pc;
    cpu_pkg::data_t idl_q;                  // Held input data latch
    cpu_pkg::data_t zp;                     // Zero-page address
    cpu_pkg::data_t dbuf;                   // Outgoing write data
    cpu_pkg::addr_t branch_offset;

    // Latch passes the bus through while loading so immediates execute in one cycle
    assign idl = idl_load ? mem_rdata : idl_q;

    assign branch_offset = {{8{idl_q[7]}}, idl_q};  // Sign-extended relative offset

    // Bus address and write data
    assign mem_addr  = addr_sel ? {8'h00, zp} : pc;
    assign mem_wdata = dbuf;

    // Program counter, accumulator and flags
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc    <= RESET_PC;
            acc   <= '0;
            flags <= '0;
        end else if (rdy) begin
            if (pc_branch) begin
                pc <= pc + branch_offset;   // PC already points past the operand
            end else if (pc_inc) begin
                pc <= pc + 16'd1;
            end

            if (acc_load) begin
                acc <= acc_from_alu ? alu_result : mem_rdata;
            end

            // Per-bit flag update
            flags <= (flags & ~flags_load) | (alu_flags & flags_load);
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        if (rdy) begin
            if (idl_load) begin
                idl_q <= mem_rdata;
            end
            if (zp_load) begin
                zp <= mem_rdata;
            end
            if (dbuf_load) begin
                // ALU result for read-modify-write, accumulator for stores
                dbuf <= acc_from_alu ? alu_result : acc;
            end
        end
    end

    // The decoder never asks for increment and branch in the same cycle
    a_pc_one_source: assert property (
        @(posedge clk) disable iff (!arst_n) !(pc_inc && pc_branch)
    );

endmodule

// File: src/instruction_decode.sv
`timescale 1ns/1ps

module instruction_decode (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             rdy,
    input  cpu_pkg::data_t   mem_rdata,
    input  cpu_pkg::flags_t  flags,
    output logic             sync,
    output logic             pc_inc,
    output logic             pc_branch,
    output logic             addr_sel,
    output logic             idl_load,
    output logic             zp_load,
    output logic             acc_load,
    output logic             acc_from_alu,
    output logic             dbuf_load,
    output logic             mem_we,
    output cpu_pkg::flags_t  flags_load,
    output cpu_pkg::alu_op_t alu_op
);

    cpu_pkg::decode_state_t state;
    cpu_pkg::decode_state_t next_state;
    cpu_pkg::data_t         opcode;         // Opcode of the instruction in flight
    logic                   running;        // Low for the idle cycle out of reset
    logic                   branch_taken;

    // BEQ tests Z, BMI tests N
    assign branch_taken = (opcode == cpu_pkg::OP_BEQ) ? flags[cpu_pkg::FLAG_Z]
                                                      : flags[cpu_pkg::FLAG_N];

    always_comb begin
        next_state   = state;
        sync         = 1'b0;
        pc_inc       = 1'b0;
        pc_branch    = 1'b0;
        addr_sel     = 1'b0;
        idl_load     = 1'b0;
        zp_load      = 1'b0;
        acc_load     = 1'b0;
        acc_from_alu = 1'b0;
        dbuf_load    = 1'b0;
        mem_we       = 1'b0;
        flags_load   = cpu_pkg::FLAGS_NONE;
        alu_op       = cpu_pkg::ALU_PASS_M;

        case (state)
            cpu_pkg::S_FETCH: begin
                if (running) begin
                    sync       = 1'b1;
                    pc_inc     = 1'b1;
                    next_state = cpu_pkg::S_OPERAND;
                end
            end
            cpu_pkg::S_OPERAND: begin
                next_state = cpu_pkg::S_FETCH;
                case (opcode)
                    cpu_pkg::OP_LDA_IMM: begin
                        pc_inc     = 1'b1;
                        idl_load   = 1'b1;      // Latch is transparent, ALU sees the byte now
                        acc_load   = 1'b1;      // Accumulator straight from the bus
                        flags_load = cpu_pkg::FLAGS_ZN;
                    end
                    cpu_pkg::OP_ADC_IMM: begin
                        pc_inc       = 1'b1;
                        idl_load     = 1'b1;
                        alu_op       = cpu_pkg::ALU_ADC;
                        acc_load     = 1'b1;
                        acc_from_alu = 1'b1;
                        flags_load   = cpu_pkg::FLAGS_CZN;
                    end
                    cpu_pkg::OP_ASL_A: begin
                        // Single byte, the operand read is discarded
                        alu_op       = cpu_pkg::ALU_ASL_A;
                        acc_load     = 1'b1;
                        acc_from_alu = 1'b1;
                        flags_load   = cpu_pkg::FLAGS_CZN;
                    end
                    cpu_pkg::OP_LDA_ZPG,
                    cpu_pkg::OP_ASL_ZPG: begin
                        pc_inc     = 1'b1;
                        zp_load    = 1'b1;
                        next_state = cpu_pkg::S_ZPG_READ;
                    end
                    cpu_pkg::OP_STA_ZPG: begin
                        pc_inc     = 1'b1;
                        zp_load    = 1'b1;
                        dbuf_load  = 1'b1;      // Buffer takes the accumulator
                        next_state = cpu_pkg::S_WRITE;
                    end
                    cpu_pkg::OP_BEQ,
                    cpu_pkg::OP_BMI: begin
                        pc_inc   = 1'b1;
                        idl_load = 1'b1;        // Hold the offset for S_BRANCH
                        if (branch_taken) begin
                            next_state = cpu_pkg::S_BRANCH;
                        end
                    end
                    default: begin
                        // NOP and unknown opcodes fall through as one-byte NOPs
                    end
                endcase
            end
            cpu_pkg::S_ZPG_READ: begin
                addr_sel = 1'b1;
                idl_load = 1'b1;
                if (opcode == cpu_pkg::OP_LDA_ZPG) begin
                    acc_load   = 1'b1;
                    flags_load = cpu_pkg::FLAGS_ZN;
                    next_state = cpu_pkg::S_FETCH;
                end else begin
                    next_state = cpu_pkg::S_MODIFY;
                end
            end
            cpu_pkg::S_MODIFY: begin
                addr_sel     = 1'b1;            // Keep the zero-page address on the bus
                alu_op       = cpu_pkg::ALU_ASL_M;
                acc_from_alu = 1'b1;            // Steers the ALU result into the buffer
                dbuf_load    = 1'b1;
                flags_load   = cpu_pkg::FLAGS_CZN;
                next_state   = cpu_pkg::S_WRITE;
            end
            cpu_pkg::S_WRITE: begin
                addr_sel   = 1'b1;
                mem_we     = 1'b1;
                next_state = cpu_pkg::S_FETCH;
            end
            cpu_pkg::S_BRANCH: begin
                pc_branch  = 1'b1;
                next_state = cpu_pkg::S_FETCH;
            end
            default: next_state = cpu_pkg::S_FETCH;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= cpu_pkg::S_FETCH;
            opcode  <= cpu_pkg::OP_NOP;
            running <= 1'b0;
        end else if (rdy) begin
            state   <= next_state;
            running <= 1'b1;
            if (sync) begin
                opcode <= mem_rdata;            // Capture the opcode on fetch
            end
        end
    end

    // A write cycle is never an opcode fetch
    a_no_write_on_fetch: assert property (
        @(posedge clk) disable iff (!arst_n) !(mem_we && sync)
    );

    a_legal_state: assert property (
        @(posedge clk) disable iff (!arst_n)
        state inside {cpu_pkg::S_FETCH, cpu_pkg::S_OPERAND, cpu_pkg::S_ZPG_READ,
                      cpu_pkg::S_MODIFY, cpu_pkg::S_WRITE, cpu_pkg::S_BRANCH}
    );

endmodule

// File: src/cpu_core.sv
`timescale 1ns/1ps

module cpu_core #(
    parameter cpu_pkg::addr_t RESET_PC = 16'h0200
) (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           rdy,
    input  cpu_pkg::data_t mem_rdata,
    output cpu_pkg::addr_t mem_addr,
    output cpu_pkg::data_t mem_wdata,
    output logic           mem_we,
    output logic           sync
);

    // Decoder to datapath strobes
    logic             pc_inc;
    logic             pc_branch;
    logic             addr_sel;
    logic             idl_load;
    logic             zp_load;
    logic             acc_load;
    logic             acc_from_alu;
    logic             dbuf_load;
    cpu_pkg::flags_t  flags_load;
    cpu_pkg::alu_op_t alu_op;

    // Datapath and ALU values
    cpu_pkg::data_t   acc;
    cpu_pkg::data_t   idl;
    cpu_pkg::flags_t  flags;
    cpu_pkg::data_t   alu_result;
    cpu_pkg::flags_t  alu_flags;

    instruction_decode u_decode (
        .clk         (clk),
        .arst_n      (arst_n),
        .rdy         (rdy),
        .mem_rdata   (mem_rdata),
        .flags       (flags),
        .sync        (sync),
        .pc_inc      (pc_inc),
        .pc_branch   (pc_branch),
        .addr_sel    (addr_sel),
        .idl_load    (idl_load),
        .zp_load     (zp_load),
        .acc_load    (acc_load),
        .acc_from_alu(acc_from_alu),
        .dbuf_load   (dbuf_load),
        .mem_we      (mem_we),
        .flags_load  (flags_load),
        .alu_op      (alu_op)
    );

    datapath #(
        .RESET_PC(RESET_PC)
    ) u_datapath (
        .clk         (clk),
        .arst_n      (arst_n),
        .rdy         (rdy),
        .mem_rdata   (mem_rdata),
        .pc_inc      (pc_inc),
        .pc_branch   (pc_branch),
        .addr_sel    (addr_sel),
        .idl_load    (idl_load),
        .zp_load     (zp_load),
        .acc_load    (acc_load),
        .acc_from_alu(acc_from_alu),
        .dbuf_load   (dbuf_load),
        .flags_load  (flags_load),
        .alu_result  (alu_result),
        .alu_flags   (alu_flags),
        .acc         (acc),
        .idl         (idl),
        .flags       (flags),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata)
    );

    alu u_alu (
        .alu_op   (alu_op),
        .acc      (acc),
        .idl      (idl),
        .carry_in (flags[cpu_pkg::FLAG_C]),
        .result   (alu_result),
        .flags_out(alu_flags)
    );

endmodule

// File: dv/cpu_core_tb.sv
`timescale 1ns/1ps

module cpu_core_tb;

    localparam cpu_pkg::addr_t RESET_PC  = 16'h0200;
    localparam logic [31:0]    SEED      = 32'hc9ec_2f5d;
    localparam int             N_GROUPS  = 60;              // Instruction groups per program
    localparam int             MAX_INSTR = 3 * N_GROUPS;
    localparam int             ZP_WINDOW = 8;               // Small so stores and loads collide
    localparam int             PAD_LEN   = 16;
    localparam int             WATCHDOG_CYCLES = 2 * ((MAX_INSTR + PAD_LEN) * 6 * 4 + 3 + 2);

    logic            clk;
    logic            arst_n = 1'b0;
    logic            rdy = 1'b0;
    cpu_pkg::data_t  mem_rdata;
    cpu_pkg::addr_t  mem_addr;
    cpu_pkg::data_t  mem_wdata;
    logic            mem_we;
    logic            sync;

    cpu_pkg::data_t  mem [0:65535];
    cpu_pkg::data_t  ref_mem [0:65535];             // Program image, then model memory
    cpu_pkg::addr_t  starts [0:MAX_INSTR];          // Instruction start addresses
    int              branches [$];                  // Indices of branch instructions
    int              n_instr;
    cpu_pkg::addr_t  gen_pc;
    cpu_pkg::addr_t  prog_end;
    integer          seed;
    integer          gen_seed;
    cpu_pkg::addr_t  m_pc;
    cpu_pkg::data_t  m_a;
    cpu_pkg::flags_t m_flags;
    cpu_pkg::addr_t  exp_pc;
    logic            exp_we;
    cpu_pkg::addr_t  exp_waddr;
    cpu_pkg::data_t  exp_wdata;
    logic            random_rdy = 1'b0;
    logic            checking;
    logic            phase_done;
    string           test_name;
    int              mismatches;
    int              other_errors;

    cpu_core #(
        .RESET_PC(RESET_PC)
    ) DUT (
        .clk      (clk),
        .arst_n   (arst_n),
        .rdy      (rdy),
        .mem_rdata(mem_rdata),
        .mem_addr (mem_addr),
        .mem_wdata(mem_wdata),
        .mem_we   (mem_we),
        .sync     (sync)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    assign mem_rdata = mem[mem_addr];               // Combinational read

    always @(posedge clk) begin
        if (mem_we && rdy) begin
            mem[mem_addr] <= mem_wdata;
        end
        rdy <= random_rdy ? (($random(seed) % 4) != 0) : 1'b1;    // High about 3 in 4
    end

    function automatic int rand_below(input int n);
        int r;
        r = $random(gen_seed);
        return (r & 32'h7fff_ffff) % n;
    endfunction

    // ASL A, NOP and unknown opcodes are one byte long
    function automatic int instr_len(input cpu_pkg::data_t op);
        return (op inside {cpu_pkg::OP_LDA_IMM, cpu_pkg::OP_LDA_ZPG, cpu_pkg::OP_STA_ZPG,
                           cpu_pkg::OP_ASL_ZPG, cpu_pkg::OP_ADC_IMM, cpu_pkg::OP_BEQ,
                           cpu_pkg::OP_BMI}) ? 2 : 1;
    endfunction

    task automatic emit_instr(input cpu_pkg::data_t op, input cpu_pkg::data_t arg);
        starts[n_instr]         = gen_pc;
        ref_mem[gen_pc]         = op;
        ref_mem[gen_pc + 16'd1] = arg;              // Overwritten later for one-byte opcodes
        gen_pc                  = gen_pc + instr_len(op);
        n_instr++;
    endtask

    task automatic emit_branch(input cpu_pkg::data_t op);
        branches.push_back(n_instr);
        emit_instr(op, 8'h00);
    endtask

    task automatic load_program();
        int             k;
        int             t;
        cpu_pkg::data_t v;
        cpu_pkg::addr_t offset;
        gen_seed = SEED;
        gen_pc   = RESET_PC;
        n_instr  = 0;
        branches.delete();
        for (int i = 0; i < 65536; i++) begin
            ref_mem[i] = i[15:8] ^ i[7:0] ^ 8'hA5;
        end
        for (int i = 0; i < ZP_WINDOW; i++) begin
            ref_mem[i] = rand_below(256);
        end
        for (int g = 0; g < N_GROUPS; g++) begin
            v = rand_below(256);
            case (rand_below(8))
                0: begin                                    // Load and store
                    emit_instr(cpu_pkg::OP_LDA_IMM, rand_below(256));
                    emit_instr(cpu_pkg::OP_STA_ZPG, rand_below(ZP_WINDOW));
                end
                1: begin                                    // Byte copy
                    emit_instr(cpu_pkg::OP_LDA_ZPG, rand_below(ZP_WINDOW));
                    emit_instr(cpu_pkg::OP_STA_ZPG, rand_below(ZP_WINDOW));
                end
                2: begin                                    // Shifted carry lands in A
                    emit_instr(cpu_pkg::OP_ASL_ZPG, rand_below(ZP_WINDOW));
                    emit_instr(cpu_pkg::OP_ADC_IMM, 8'h00);
                    emit_instr(cpu_pkg::OP_STA_ZPG, rand_below(ZP_WINDOW));
                end
                3: begin
                    emit_instr(cpu_pkg::OP_ADC_IMM, rand_below(256));
                    emit_instr(cpu_pkg::OP_ADC_IMM, rand_below(256));
                    emit_instr(cpu_pkg::OP_STA_ZPG, rand_below(ZP_WINDOW));
                end
                4: begin
                    emit_instr(cpu_pkg::OP_LDA_IMM, v[1] ? 8'h00 : v);  // Zero half the time
                    emit_branch(v[0] ? cpu_pkg::OP_BEQ : cpu_pkg::OP_BMI);
                end
                5: begin
                    emit_instr(cpu_pkg::OP_ADC_IMM, v);
                    emit_branch(v[0] ? cpu_pkg::OP_BEQ : cpu_pkg::OP_BMI);
                end
                6: begin
                    emit_instr(cpu_pkg::OP_ASL_A, 8'h00);
                    emit_instr(cpu_pkg::OP_STA_ZPG, rand_below(ZP_WINDOW));
                end
                default: emit_instr(cpu_pkg::OP_NOP, 8'h00);
            endcase
        end
        starts[n_instr] = gen_pc;
        prog_end        = gen_pc;
        for (int i = 0; i < PAD_LEN; i++) begin
            ref_mem[gen_pc + i] = cpu_pkg::OP_NOP;
        end
        // Forward targets on one of the next three instruction starts
        foreach (branches[b]) begin
            k = branches[b];
            t = k + 1 + rand_below(3);
            if (t > n_instr) begin
                t = n_instr;
            end
            offset = starts[t] - starts[k] - 16'd2;
            ref_mem[starts[k] + 16'd1] = offset[7:0];
        end
        for (int i = 0; i < 65536; i++) begin
            mem[i] <= ref_mem[i];
        end
    endtask

    // Executes one instruction on the model, returns the next fetch address
    function automatic cpu_pkg::addr_t ref_step(output logic we, output cpu_pkg::addr_t wa,
                                                 output cpu_pkg::data_t wd);
        cpu_pkg::data_t op;
        cpu_pkg::data_t b1;
        cpu_pkg::data_t res;
        int             total;                      // Unbounded A + M + C
        int             rel;                        // Branch offset as a signed number
        logic           taken;
        op    = ref_mem[m_pc];
        b1    = ref_mem[m_pc + 16'd1];
        we    = 1'b0;
        wa    = {8'h00, b1};
        wd    = m_a;
        res   = m_a;
        total = int'(m_a) + int'(b1) + int'(m_flags[cpu_pkg::FLAG_C]);
        rel   = (b1 > 8'd127) ? int'(b1) - 256 : int'(b1);
        taken = (op == cpu_pkg::OP_BEQ) ? m_flags[cpu_pkg::FLAG_Z] : m_flags[cpu_pkg::FLAG_N];
        m_pc  = m_pc + instr_len(op);
        case (op)
            cpu_pkg::OP_LDA_IMM: res = b1;
            cpu_pkg::OP_LDA_ZPG: res = ref_mem[wa];
            cpu_pkg::OP_ADC_IMM: begin
                res                      = total % 256;
                m_flags[cpu_pkg::FLAG_C] = (total > 255);
            end
            cpu_pkg::OP_ASL_A:   {m_flags[cpu_pkg::FLAG_C], res} = {m_a, 1'b0};
            cpu_pkg::OP_ASL_ZPG: begin
                {m_flags[cpu_pkg::FLAG_C], res} = {ref_mem[wa], 1'b0};
                ref_mem[wa] = res;
                we          = 1'b1;
                wd          = res;
            end
            cpu_pkg::OP_STA_ZPG: begin
                ref_mem[wa] = m_a;
                we          = 1'b1;
            end
            cpu_pkg::OP_BEQ,
            cpu_pkg::OP_BMI: begin
                if (taken) begin
                    m_pc = m_pc + rel;
                end
            end
            default: ;
        endcase
        if (op inside {cpu_pkg::OP_LDA_IMM, cpu_pkg::OP_LDA_ZPG, cpu_pkg::OP_ADC_IMM,
                       cpu_pkg::OP_ASL_A}) begin
            m_a = res;
        end
        if (op inside {cpu_pkg::OP_LDA_IMM, cpu_pkg::OP_LDA_ZPG, cpu_pkg::OP_ADC_IMM,
                       cpu_pkg::OP_ASL_A, cpu_pkg::OP_ASL_ZPG}) begin
            m_flags[cpu_pkg::FLAG_Z] = (res == 8'h00);
            m_flags[cpu_pkg::FLAG_N] = res[7];
        end
        return m_pc;
    endfunction

    task automatic check_addr(input string what, input cpu_pkg::addr_t expected,
                              input cpu_pkg::addr_t actual);
        if (actual !== expected) begin
            mismatches++;
            $display("MISMATCH %s %s: expected %h, actual %h", test_name, what, expected, actual);
        end
    endtask

    task automatic check_data(input string what, input cpu_pkg::data_t expected,
                              input cpu_pkg::data_t actual);
        if (actual !== expected) begin
            mismatches++;
            $display("MISMATCH %s %s: expected %h, actual %h", test_name, what, expected, actual);
        end
    endtask

    // Bus outputs are sampled mid-cycle, where they are stable
    always @(negedge clk) begin
        if (checking) begin
            if (!arst_n && (sync || mem_we)) begin
                other_errors++;
                $display("%s: sync or mem_we is high during reset", test_name);
            end
            if (arst_n && rdy && mem_we) begin
                if (!exp_we) begin
                    other_errors++;
                    $display("%s: unexpected write to address %h", test_name, mem_addr);
                end else begin
                    check_addr("write address", exp_waddr, mem_addr);
                    check_data("write data", exp_wdata, mem_wdata);
                end
                exp_we = 1'b0;
            end
            if (arst_n && rdy && sync) begin
                if (exp_we) begin
                    other_errors++;
                    $display("%s: expected write to %h did not happen", test_name, exp_waddr);
                end
                check_addr("fetch address", exp_pc, mem_addr);
                exp_pc = ref_step(exp_we, exp_waddr, exp_wdata);
                if (mem_addr >= prog_end) begin
                    phase_done = 1'b1;
                end
            end
        end
    end

    task automatic run_phase(input string name, input logic stall);
        @(posedge clk);
        arst_n     <= 1'b0;
        random_rdy <= stall;
        test_name  = name;
        load_program();
        m_pc       = RESET_PC;
        m_a        = '0;
        m_flags    = '0;
        exp_pc     = RESET_PC;
        exp_we     = 1'b0;
        phase_done = 1'b0;
        checking   = 1'b1;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        wait (phase_done);
        @(posedge clk);
        checking = 1'b0;
        for (int i = 0; i < ZP_WINDOW; i++) begin
            check_data("zero page", ref_mem[i], mem[i]);
        end
    endtask

    task automatic finish_run();
        $display("Mismatches: %0d, other errors: %0d", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    endtask

    initial begin
        seed         = SEED;
        mismatches   = 0;
        other_errors = 0;
        checking     = 1'b0;
        run_phase("rdy_held", 1'b0);
        run_phase("rdy_random", 1'b1);
        finish_run();
    end

    // Six cycles per instruction, four times over for stalls
    initial begin
        #(WATCHDOG_CYCLES * 4);
        other_errors++;
        $display("Watchdog expired in %s, the core stopped fetching", test_name);
        finish_run();
    end

endmodule

// File: cpu_core.f
src/cpu_pkg.sv
src/alu.sv
src/datapath.sv
src/instruction_decode.sv
src/cpu_core.sv
dv/cpu_core_tb.sv
